/* mem_pipe.f */
+incdir+logic
logic/mem_pipe_pkg.sv
logic/mem1_stage.sv
logic/data_scratchpad.sv
logic/mem2_stage.sv
logic/writeback_stage.sv
logic/mem_pipe_top.sv
verification/mem_pipe_tb.sv

/* Bender.yml */
package:
  name: mem_pipe

sources:
  - include_dirs:
      - logic
    files:
      - logic/mem_pipe_pkg.sv
      - logic/mem1_stage.sv
      - logic/data_scratchpad.sv
      - logic/mem2_stage.sv
      - logic/writeback_stage.sv
      - logic/mem_pipe_top.sv
      - verification/mem_pipe_tb.sv

/* verification/mem_pipe_tb.sv */
////////////////////
// random memory traffic checked against an in-order model
// flush is raised only in unstalled cycles
// outputs are sampled 1 ns after each rising edge
////////////////////

`timescale 1ns/1ps

`include "mem_pipe_settings.svh"

module mem_pipe_tb;

    import mem_pipe_pkg::*;

    localparam int N_RAND      = 400;
    localparam int STIM_CYCLES = 5 + 34 + N_RAND + `MEM_PIPE_DEPTH + 4;
    localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 100;

    typedef struct packed {
        logic       valid;
        mem_op_e    op;
        amo_op_e    amo;
        rd_src_e    src;
        word_t      addr;
        word_t      rs2;
        logic [4:0] idx;
        logic       we;
    } instr_t;

    typedef struct packed {
        logic       wen;
        logic [4:0] idx;
        word_t      data;
    } wb_t;

    logic       clk, rst_n, stall, flush, in_valid, in_rd_we;
    mem_op_e    in_mem_op;
    amo_op_e    in_amo_op;
    rd_src_e    in_rd_src;
    word_t      in_addr, in_rs2_val;
    logic [4:0] in_rd_idx;
    logic       wb_valid, rd_wen;
    logic [4:0] rd_idx;
    word_t      rd_wdata;

    integer seed      = 69;
    int     errors    = 0;
    int     checks    = 0;
    int     cycle_cnt = 0;
    string  test_name = "reset";
    word_t  model_mem [`MEM_PIPE_DEPTH];
    wb_t    exp_q [$];
    instr_t cur, s1, s2; // s1 and s2 shadow memory 1 and memory 2

    mem_pipe_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    initial begin
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
        end
        $display("timeout after %0d cycles, pipeline never drained", cycle_cnt);
        $display("** FAIL **");
        $finish;
    end

    function automatic int unsigned rand_below(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic instr_t make_instr(mem_op_e op, amo_op_e amo, word_t addr, word_t rs2,
                                          logic [4:0] idx, logic we);
        instr_t i;
        i.valid = 1'b1;
        i.op    = op;
        i.amo   = amo;
        i.src   = (op == MEM_OP_LOAD || op == MEM_OP_AMO) ? RD_SRC_MEM : RD_SRC_ALU;
        i.addr  = addr;
        i.rs2   = rs2;
        i.idx   = idx;
        i.we    = we;
        return i;
    endfunction

    function automatic instr_t rand_instr();
        instr_t i;
        word_t  r;
        word_t  v;
        r = $random(seed);
        v = $random(seed);
        i = make_instr(mem_op_e'(rand_below(4)), amo_op_e'(rand_below(9)), r, v,
                       5'(rand_below(32)), rand_below(8) != 0);
        if (i.op != MEM_OP_NONE) begin
            i.addr = {r[31:8], 3'b000, r[4:0]}; // keep to words 0..7
        end
        if (i.op == MEM_OP_STORE) begin
            i.we = 1'b0;
        end
        i.valid = rand_below(8) != 0;
        return i;
    endfunction

    // RV32A rules, signed compares through int
    function automatic word_t amo_expect(amo_op_e op, word_t m, word_t r);
        int sm;
        int sr;
        sm = m;
        sr = r;
        case (op)
            AMO_OP_SWAP: return r;
            AMO_OP_ADD:  return m + r;
            AMO_OP_AND:  return m & r;
            AMO_OP_OR:   return m | r;
            AMO_OP_XOR:  return m ^ r;
            AMO_OP_MIN:  return (sm <= sr) ? m : r;
            AMO_OP_MAX:  return (sm >= sr) ? m : r;
            AMO_OP_MINU: return (m <= r) ? m : r;
            AMO_OP_MAXU: return (m >= r) ? m : r;
            default:     return '0;
        endcase
    endfunction

    task automatic retire(instr_t i);
        logic [`MEM_PIPE_AW-1:0] w;
        word_t old;
        wb_t   e;
        w   = i.addr[`MEM_PIPE_AW+1:2];
        old = model_mem[w];
        if (i.op == MEM_OP_STORE) begin
            model_mem[w] = i.rs2;
        end else if (i.op == MEM_OP_AMO) begin
            model_mem[w] = amo_expect(i.amo, old, i.rs2);
        end
        e.wen  = i.we && (i.idx != 5'd0); // x0 never written
        e.idx  = i.idx;
        e.data = (i.src == RD_SRC_MEM) ? old : i.addr;
        exp_q.push_back(e);
    endtask

    // one edge of the model, uses the inputs that were held up to it
    task automatic update_model();
        if (!stall) begin
            if (s2.valid && !flush) begin
                retire(s2);
            end
            s2 = s1;
            s1 = cur;
        end
    endtask

    task automatic report_value(string what, word_t exp, word_t act);
        errors++;
        $display("[FAIL] %s %s: expected %h actual %h", test_name, what, exp, act);
    endtask

    task automatic check_outputs();
        wb_t e;
        checks++;
        if (wb_valid !== 1'b1 && rd_wen !== 1'b0) begin
            errors++;
            $display("%s: rd_wen is active without wb_valid", test_name);
        end
        if (wb_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("%s: writeback with no instruction in flight", test_name);
            end else begin
                e = exp_q.pop_front();
                if (rd_wen !== e.wen) begin
                    report_value("rd_wen", e.wen, rd_wen);
                end
                if (rd_idx !== e.idx) begin
                    report_value("rd_idx", e.idx, rd_idx);
                end
                if (e.wen && rd_wdata !== e.data) begin
                    report_value("rd_wdata", e.data, rd_wdata);
                end
            end
        end
    endtask

    task automatic put(instr_t i, logic s, logic f);
        cur        = i;
        in_valid   = i.valid;
        in_mem_op  = i.op;
        in_amo_op  = i.amo;
        in_rd_src  = i.src;
        in_addr    = i.addr;
        in_rs2_val = i.rs2;
        in_rd_idx  = i.idx;
        in_rd_we   = i.we;
        stall      = s;
        flush      = f;
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
        update_model();
        check_outputs();
    endtask

    task automatic issue(instr_t i);
        put(i, 1'b0, 1'b0);
        tick();
    endtask

    initial begin
        instr_t idle;
        logic   st;
        logic   fl;
        idle = '0;
        s1   = '0;
        s2   = '0;
        for (int w = 0; w < `MEM_PIPE_DEPTH; w++) begin
            model_mem[w] = '0;
        end
        rst_n = 1'b0;
        put(make_instr(MEM_OP_LOAD, AMO_OP_SWAP, 32'h8, '0, 5'd7, 1'b1), 1'b0, 1'b0);
        repeat (5) begin
            @(posedge clk);
            #1;
            if (wb_valid !== 1'b0 || rd_wen !== 1'b0) begin
                errors++;
                $display("reset: writeback port active during reset");
            end
        end
        rst_n = 1'b1;
        tick(); // load held through reset gets accepted here

        test_name = "store_load";
        issue(make_instr(MEM_OP_STORE, AMO_OP_SWAP, 32'hc, 32'h1234_5a5a, 5'd0, 1'b0));
        issue(make_instr(MEM_OP_LOAD, AMO_OP_SWAP, 32'hc, '0, 5'd5, 1'b1));
        issue(make_instr(MEM_OP_LOAD, AMO_OP_SWAP, 32'h18, '0, 5'd6, 1'b1)); // untouched

        test_name = "amo";
        for (int k = 0; k < 9; k++) begin
            issue(make_instr(MEM_OP_STORE, AMO_OP_SWAP, 32'h10, 32'hffff_fff0, 5'd0, 1'b0));
            issue(make_instr(MEM_OP_AMO, amo_op_e'(k), 32'h10, 32'd7, 5'(k + 1), 1'b1));
            issue(make_instr(MEM_OP_LOAD, AMO_OP_SWAP, 32'h10, '0, 5'd20, 1'b1));
        end

        test_name = "alu";
        issue(make_instr(MEM_OP_NONE, AMO_OP_SWAP, 32'h8765_4321, '0, 5'd0, 1'b1));
        issue(make_instr(MEM_OP_NONE, AMO_OP_SWAP, 32'h0bad_0001, '0, 5'd9, 1'b0));
        issue(make_instr(MEM_OP_NONE, AMO_OP_SWAP, 32'h1357_9bdf, '0, 5'd10, 1'b1));

        test_name = "random";
        for (int n = 0; n < N_RAND; n++) begin
            st = rand_below(5) == 0;
            fl = !st && (rand_below(12) == 0);
            put(rand_instr(), st, fl);
            tick();
        end

        // read back every word against the model array
        test_name = "drain";
        for (int w = 0; w < `MEM_PIPE_DEPTH; w++) begin
            issue(make_instr(MEM_OP_LOAD, AMO_OP_SWAP, 32'(w * 4), '0,
                             5'(w % 31 + 1), 1'b1));
        end
        put(idle, 1'b0, 1'b0);
        repeat (4) tick(); // last two loads retire, then the port stays quiet
        if (exp_q.size() != 0) begin
            errors++;
            $display("drain: %0d instructions never reached writeback", exp_q.size());
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* logic/mem_pipe_top.sv */
////////////////////
// memory back end, two cycles from accept to writeback
// stall and flush come from outside, no ready
////////////////////

`timescale 1ns/1ps

`include "mem_pipe_settings.svh"

module mem_pipe_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  in_valid,
    input  mem_pipe_pkg::mem_op_e in_mem_op,
    input  mem_pipe_pkg::amo_op_e in_amo_op,
    input  mem_pipe_pkg::rd_src_e in_rd_src,
    input  mem_pipe_pkg::word_t   in_addr,
    input  mem_pipe_pkg::word_t   in_rs2_val,
    input  logic [4:0]            in_rd_idx,
    input  logic                  in_rd_we,
    output logic                  wb_valid,
    output logic                  rd_wen,
    output logic [4:0]            rd_idx,
    output mem_pipe_pkg::word_t   rd_wdata
);

    import mem_pipe_pkg::*;

    logic       m1_valid, m1_rd_we;
    mem_op_e    m1_mem_op;
    amo_op_e    m1_amo_op;
    rd_src_e    m1_rd_src;
    word_t      m1_addr, m1_rs2_val;
    logic [4:0] m1_rd_idx;
    logic [`MEM_PIPE_AW-1:0] rd_addr, wr_addr;
    word_t      rd_data, wr_data;
    logic       wr_en;
    logic       m2_valid, m2_rd_we;
    rd_src_e    m2_rd_src;
    logic [4:0] m2_rd_idx;
    word_t      m2_alu_result, m2_mem_rdata;

    mem1_stage u_mem1 (.*);

    data_scratchpad u_spad (.*);

    mem2_stage u_mem2 (.*);

    writeback_stage u_wb (.*);

endmodule

/* logic/writeback_stage.sv */
////////////////////
// writeback register and register-file write port
// writes to x0 are dropped
////////////////////

`timescale 1ns/1ps

module writeback_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  logic                  m2_valid,
    input  logic                  m2_rd_we,
    input  mem_pipe_pkg::rd_src_e m2_rd_src,
    input  logic [4:0]            m2_rd_idx,
    input  mem_pipe_pkg::word_t   m2_alu_result,
    input  mem_pipe_pkg::word_t   m2_mem_rdata,
    output logic                  wb_valid,
    output logic                  rd_wen,
    output logic [4:0]            rd_idx,
    output mem_pipe_pkg::word_t   rd_wdata
);

    import mem_pipe_pkg::*;

    logic    rd_we_q;
    rd_src_e rd_src_q;
    word_t   alu_q;
    word_t   mem_q;

    // a stalled edge leaves an empty slot here
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= m2_valid && !stall;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            rd_we_q  <= m2_rd_we;
            rd_src_q <= m2_rd_src;
            rd_idx   <= m2_rd_idx;
            alu_q    <= m2_alu_result;
            mem_q    <= m2_mem_rdata;
        end
    end

    assign rd_wdata = (rd_src_q == RD_SRC_MEM) ? mem_q : alu_q;
    assign rd_wen   = wb_valid && rd_we_q && (rd_idx != 5'd0);

endmodule

/* logic/mem2_stage.sv */
////////////////////
// memory 2 register, atomic ALU and scratchpad write
// flush kills the instruction held here
// load data is kept locally across a stall
////////////////////

`timescale 1ns/1ps

`include "mem_pipe_settings.svh"

module mem2_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    m1_valid,
    input  mem_pipe_pkg::mem_op_e   m1_mem_op,
    input  mem_pipe_pkg::amo_op_e   m1_amo_op,
    input  mem_pipe_pkg::rd_src_e   m1_rd_src,
    input  mem_pipe_pkg::word_t     m1_addr,
    input  mem_pipe_pkg::word_t     m1_rs2_val,
    input  logic [4:0]              m1_rd_idx,
    input  logic                    m1_rd_we,
    input  mem_pipe_pkg::word_t     rd_data,
    output logic                    wr_en,
    output logic [`MEM_PIPE_AW-1:0] wr_addr,
    output mem_pipe_pkg::word_t     wr_data,
    output logic                    m2_valid,
    output logic                    m2_rd_we,
    output mem_pipe_pkg::rd_src_e   m2_rd_src,
    output logic [4:0]              m2_rd_idx,
    output mem_pipe_pkg::word_t     m2_alu_result,
    output mem_pipe_pkg::word_t     m2_mem_rdata
);

    import mem_pipe_pkg::*;

    logic    valid_q;
    mem_op_e mem_op_q;
    amo_op_e amo_op_q;
    rd_src_e rd_src_q;
    word_t   addr_q;
    word_t   rs2_q;
    logic [4:0] rd_idx_q;
    logic    rd_we_q;
    logic    hold_valid; // load data parked in load_hold
    word_t   load_hold;
    word_t   mem_rdata;
    word_t   amo_result;
    logic    writes_mem;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= m1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            mem_op_q <= m1_mem_op;
            amo_op_q <= m1_amo_op;
            rd_src_q <= m1_rd_src;
            addr_q   <= m1_addr;
            rs2_q    <= m1_rs2_val;
            rd_idx_q <= m1_rd_idx;
            rd_we_q  <= m1_rd_we;
        end
    end

    // the scratchpad re-reads the memory 1 address while stalled,
    // so park the word read for this instruction on the first stalled edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
        end else begin
            hold_valid <= stall;
        end
    end

    always_ff @(posedge clk) begin
        if (stall && !hold_valid) begin
            load_hold <= rd_data;
        end
    end

    assign mem_rdata = hold_valid ? load_hold : rd_data;

    always_comb begin
        unique case (amo_op_q)
            AMO_OP_SWAP: amo_result = rs2_q;
            AMO_OP_ADD:  amo_result = mem_rdata + rs2_q;
            AMO_OP_AND:  amo_result = mem_rdata & rs2_q;
            AMO_OP_OR:   amo_result = mem_rdata | rs2_q;
            AMO_OP_XOR:  amo_result = mem_rdata ^ rs2_q;
            AMO_OP_MIN:  amo_result = ($signed(mem_rdata) < $signed(rs2_q)) ? mem_rdata : rs2_q;
            AMO_OP_MAX:  amo_result = ($signed(mem_rdata) > $signed(rs2_q)) ? mem_rdata : rs2_q;
            AMO_OP_MINU: amo_result = (mem_rdata < rs2_q) ? mem_rdata : rs2_q;
            AMO_OP_MAXU: amo_result = (mem_rdata > rs2_q) ? mem_rdata : rs2_q;
            default:     amo_result = '0;
        endcase
    end

    assign writes_mem = (mem_op_q == MEM_OP_STORE) || (mem_op_q == MEM_OP_AMO);
    assign wr_en      = valid_q && writes_mem && !stall && !flush;
    assign wr_addr    = addr_q[`MEM_PIPE_AW+1:2];
    assign wr_data    = (mem_op_q == MEM_OP_AMO) ? amo_result : rs2_q;

    assign m2_valid      = valid_q && !stall && !flush;
    assign m2_rd_we      = rd_we_q;
    assign m2_rd_src     = rd_src_q;
    assign m2_rd_idx     = rd_idx_q;
    assign m2_alu_result = addr_q; // address doubles as the ALU result
    assign m2_mem_rdata  = mem_rdata; // old value for an atomic

    // front end must route atomics to the memory source
    a_amo_rd_src_mem: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_q && mem_op_q == MEM_OP_AMO) |-> rd_src_q == RD_SRC_MEM);

endmodule

/* logic/data_scratchpad.sv */
////////////////////
// word scratchpad, one read and one write port
// read data appears one cycle after rd_addr is sampled
// a write to the word being read is bypassed
////////////////////

`timescale 1ns/1ps

`include "mem_pipe_settings.svh"

module data_scratchpad (
    input  logic                    clk,
    input  logic                    wr_en,
    input  logic [`MEM_PIPE_AW-1:0] rd_addr,
    input  logic [`MEM_PIPE_AW-1:0] wr_addr,
    input  mem_pipe_pkg::word_t     wr_data,
    output mem_pipe_pkg::word_t     rd_data
);

    import mem_pipe_pkg::*;

    word_t mem [`MEM_PIPE_DEPTH];
    logic  same_word;

    // start from an all-zero image
    initial begin
        for (int i = 0; i < `MEM_PIPE_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    assign same_word = wr_en && (wr_addr == rd_addr);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read register loads every cycle, even under stall
    always_ff @(posedge clk) begin
        if (same_word) begin
            rd_data <= wr_data; // new data wins on a collision
        end else begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* logic/mem1_stage.sv */
////////////////////
// memory 1 register, drives the scratchpad read address
// low two address bits are ignored
////////////////////

`timescale 1ns/1ps

`include "mem_pipe_settings.svh"

module mem1_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  logic                  in_valid,
    input  mem_pipe_pkg::mem_op_e in_mem_op,
    input  mem_pipe_pkg::amo_op_e in_amo_op,
    input  mem_pipe_pkg::rd_src_e in_rd_src,
    input  mem_pipe_pkg::word_t   in_addr,
    input  mem_pipe_pkg::word_t   in_rs2_val,
    input  logic [4:0]            in_rd_idx,
    input  logic                  in_rd_we,
    output logic                  m1_valid,
    output mem_pipe_pkg::mem_op_e m1_mem_op,
    output mem_pipe_pkg::amo_op_e m1_amo_op,
    output mem_pipe_pkg::rd_src_e m1_rd_src,
    output mem_pipe_pkg::word_t   m1_addr,
    output mem_pipe_pkg::word_t   m1_rs2_val,
    output logic [4:0]            m1_rd_idx,
    output logic                  m1_rd_we,
    output logic [`MEM_PIPE_AW-1:0] rd_addr
);

    import mem_pipe_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m1_valid <= 1'b0;
        end else if (!stall) begin
            m1_valid <= in_valid;
        end
    end

    // payload just follows the input, valid qualifies it
    always_ff @(posedge clk) begin
        if (!stall) begin
            m1_mem_op  <= in_mem_op;
            m1_amo_op  <= in_amo_op;
            m1_rd_src  <= in_rd_src;
            m1_addr    <= in_addr;
            m1_rs2_val <= in_rs2_val;
            m1_rd_idx  <= in_rd_idx;
            m1_rd_we   <= in_rd_we;
        end
    end

    assign rd_addr = m1_addr[`MEM_PIPE_AW+1:2]; // word index

    // decoded op must be a real kind once it is valid
    a_m1_op_known: assert property (@(posedge clk) disable iff (!rst_n)
        m1_valid |-> !$isunknown(m1_mem_op));

endmodule

/* logic/mem_pipe_pkg.sv */
////////////////////
// types of the memory back end
// only aligned 32-bit words, no byte or halfword ops
////////////////////

`include "mem_pipe_settings.svh"

package mem_pipe_pkg;

    typedef logic [`MEM_PIPE_XLEN-1:0] word_t;

    typedef enum logic [1:0] {
        MEM_OP_NONE  = 2'd0,
        MEM_OP_LOAD  = 2'd1,
        MEM_OP_STORE = 2'd2,
        MEM_OP_AMO   = 2'd3
    } mem_op_e;

    // RV32A read-modify-write kinds, LR/SC not handled here
    typedef enum logic [3:0] {
        AMO_OP_SWAP = 4'd0,
        AMO_OP_ADD  = 4'd1,
        AMO_OP_AND  = 4'd2,
        AMO_OP_OR   = 4'd3,
        AMO_OP_XOR  = 4'd4,
        AMO_OP_MIN  = 4'd5,
        AMO_OP_MAX  = 4'd6,
        AMO_OP_MINU = 4'd7,
        AMO_OP_MAXU = 4'd8
    } amo_op_e;

    typedef enum logic {
        RD_SRC_ALU = 1'b0,
        RD_SRC_MEM = 1'b1 // loads and atomics
    } rd_src_e;

endpackage

/* logic/mem_pipe_settings.svh */
////////////////////
// sizes shared by every block of the memory pipe
// MEM_PIPE_AW must stay equal to log2 of MEM_PIPE_DEPTH
////////////////////

`ifndef MEM_PIPE_SETTINGS_SVH
`define MEM_PIPE_SETTINGS_SVH

`define MEM_PIPE_XLEN 32 // data word width

`define MEM_PIPE_DEPTH 64 // scratchpad words

`define MEM_PIPE_AW 6 // word address width

`endif
